/* ieu.f */
+incdir+include
verilog/procyon_types.sv
verilog/ieu_id.sv
verilog/ieu_ex.sv
verilog/ieu_wb.sv
verilog/ieu.sv
verification/ieu_tb.sv

/* run.sh */
#!/bin/sh
# Builds the ieu testbench with Verilator and runs it.
# The exit status is nonzero if the build fails or the simulation reports a failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ps \
    --top-module ieu_tb -f ieu.f \
    --Mdir obj_dir -o ieu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

./obj_dir/ieu_sim
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

/* verification/ieu_tb.sv */
// random testbench for ieu; issues only supported opcodes and expects a fixed two-cycle latency
`timescale 1ns/1ps
`default_nettype none

module ieu_tb
    import procyon_types::*;
();

    localparam int STIM_CYCLES    = 4000;
    localparam int RESET_CYCLES   = 3;
    localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;
    localparam int IDLE_CYCLES    = 4;  // quiet cycles after reset and at the end

    logic       clk;
    logic       i_reset;
    logic       i_flush;
    ieu_issue_t i_issue;
    ieu_cdb_t   o_cdb;

    ieu_cdb_t exp_id;  // what the decode register should be holding
    ieu_cdb_t exp_wb;  // what o_cdb should show
    int       cycles;
    int       n_bcast;
    int       n_redirect;
    int       n_dropped;

    ieu ieu_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_issue (i_issue),
        .o_cdb   (o_cdb)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        $display("FAILED at time %0t: %s got %h, expected %h", $time, name, got, expected);
        $display("RESULT: FAIL");
        $fatal(1, "mismatch on %s", name);
    endtask

    task automatic check_cdb(input ieu_cdb_t act, input ieu_cdb_t exp);
        if (act.valid !== exp.valid)
            report_mismatch("o_cdb.valid", 32'(act.valid), 32'(exp.valid));
        if (act.data !== exp.data)
            report_mismatch("o_cdb.data", act.data, exp.data);
        if (act.addr !== exp.addr)
            report_mismatch("o_cdb.addr", act.addr, exp.addr);
        if (act.tag !== exp.tag)
            report_mismatch("o_cdb.tag", 32'(act.tag), 32'(exp.tag));
        if (act.redirect !== exp.redirect)
            report_mismatch("o_cdb.redirect", 32'(act.redirect), 32'(exp.redirect));
    endtask

    task automatic check_idle(input ieu_cdb_t act);
        if (act.valid !== 1'b0)
            report_mismatch("o_cdb.valid", 32'(act.valid), 32'd0);
        if (act.redirect !== 1'b0)
            report_mismatch("o_cdb.redirect", 32'(act.redirect), 32'd0);
    endtask

    // RV32I semantics for the supported classes, written from the ISA rules
    function automatic ieu_cdb_t model_broadcast(input ieu_issue_t ins);
        ieu_cdb_t             exp;
        procyon_data_t        b;
        procyon_data_t        r;
        procyon_signed_data_t sa;
        procyon_signed_data_t sb;
        procyon_signed_data_t sra;
        logic [4:0]           sh;
        logic                 taken;
        exp       = '0;
        exp.valid = ins.valid;
        exp.tag   = ins.tag;
        b         = (ins.opcode == OPCODE_OP) ? ins.src_b : ins.imm;
        sh        = b[4:0];
        sa        = ins.src_a;
        sb        = b;
        sra       = sa >>> sh;
        r         = '0;
        taken     = 1'b0;
        case (ins.opcode)
            OPCODE_OP, OPCODE_OPIMM: begin
                case (ins.funct3)
                    3'b000: r = (ins.opcode == OPCODE_OP && ins.funct7_5) ?
                                ins.src_a - b : ins.src_a + b;
                    3'b001: r = ins.src_a << sh;
                    3'b010: r[0] = sa < sb;
                    3'b011: r[0] = ins.src_a < b;
                    3'b100: r = ins.src_a ^ b;
                    3'b101: r = ins.funct7_5 ? sra : ins.src_a >> sh;
                    3'b110: r = ins.src_a | b;
                    default: r = ins.src_a & b;
                endcase
                exp.data = r;
            end
            OPCODE_LUI:   exp.data = ins.imm;
            OPCODE_AUIPC: exp.data = ins.iaddr + ins.imm;
            OPCODE_JAL, OPCODE_JALR: begin
                exp.data     = ins.iaddr + 32'd4;
                exp.addr     = (ins.opcode == OPCODE_JAL) ? ins.iaddr + ins.imm
                                                          : ins.src_a + ins.imm;
                exp.redirect = 1'b1;
            end
            default: begin
                sb = ins.src_b;  // branches compare the two registers
                case (ins.funct3)
                    FUNCT3_BEQ:  taken = ins.src_a == ins.src_b;
                    FUNCT3_BNE:  taken = ins.src_a != ins.src_b;
                    FUNCT3_BLT:  taken = sa < sb;
                    FUNCT3_BGE:  taken = !(sa < sb);
                    FUNCT3_BLTU: taken = ins.src_a < ins.src_b;
                    default:     taken = !(ins.src_a < ins.src_b);
                endcase
                exp.data[0]  = taken;
                exp.addr     = ins.iaddr + ins.imm;
                exp.redirect = taken;
            end
        endcase
        return exp;
    endfunction

    function automatic ieu_issue_t random_issue(input logic valid);
        ieu_issue_t ins;
        logic [31:0] raw;
        int          pick;
        int          br_sel;
        raw          = $urandom();
        pick         = $urandom_range(12, 0);
        br_sel       = $urandom_range(5, 0);
        ins.valid    = valid;
        ins.funct3   = 3'($urandom());
        ins.funct7_5 = 1'($urandom());
        ins.iaddr    = $urandom() & 32'hffff_fffc;
        ins.src_a    = ($urandom_range(7, 0) == 0) ? 32'($urandom_range(40, 0)) : $urandom();
        ins.src_b    = ($urandom_range(3, 0) == 0) ? ins.src_a : $urandom();
        ins.tag      = 6'($urandom());
        ins.imm      = {{20{raw[11]}}, raw[11:0]};  // I format unless changed below
        if (pick < 3) begin
            ins.opcode = OPCODE_OP;
        end else if (pick < 6) begin
            ins.opcode = OPCODE_OPIMM;
        end else if (pick == 6) begin
            ins.opcode = OPCODE_LUI;
            ins.imm    = {raw[31:12], 12'b0};
        end else if (pick == 7) begin
            ins.opcode = OPCODE_AUIPC;
            ins.imm    = {raw[31:12], 12'b0};
        end else if (pick == 8) begin
            ins.opcode = OPCODE_JAL;
            ins.imm    = {{11{raw[20]}}, raw[20:1], 1'b0};
        end else if (pick == 9) begin
            ins.opcode = OPCODE_JALR;
        end else begin
            ins.opcode = OPCODE_BRANCH;
            ins.imm    = {{19{raw[12]}}, raw[12:1], 1'b0};
            ins.funct3 = (br_sel < 2) ? 3'(br_sel) : 3'(br_sel + 2);  // skip 010 and 011
        end
        return ins;
    endfunction

    // reference pipeline; reads the inputs the DUT samples at this same edge
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT_CYCLES) begin
            $display("timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
        exp_wb = exp_id;
        if (i_reset || i_flush) begin
            if (!i_reset && (exp_id.valid || i_issue.valid))
                n_dropped = n_dropped + 1;
            exp_wb.valid    = 1'b0;
            exp_wb.redirect = 1'b0;
        end
        exp_id = model_broadcast(i_issue);
        if (i_reset || i_flush)
            exp_id.valid = 1'b0;
    end

    always @(negedge clk) begin
        if (cycles > 0) begin
            if (exp_wb.valid) begin
                check_cdb(o_cdb, exp_wb);
                n_bcast = n_bcast + 1;
                if (exp_wb.redirect)
                    n_redirect = n_redirect + 1;
            end else begin
                check_idle(o_cdb);
            end
        end
    end

    initial begin
        int cycle;
        void'($urandom(32'hcd6715ef));
        cycles     = 0;
        n_bcast    = 0;
        n_redirect = 0;
        n_dropped  = 0;
        exp_id     = '0;
        exp_wb     = '0;
        i_reset    = 1'b1;
        i_flush    = 1'b0;
        i_issue    = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        i_reset <= 1'b0;

        for (cycle = 0; cycle < STIM_CYCLES; cycle++) begin
            @(posedge clk);
            if (cycle < IDLE_CYCLES) begin
                i_issue <= random_issue(1'b0);  // o_cdb must stay quiet here
                i_flush <= 1'b0;
            end else begin
                i_issue <= random_issue($urandom_range(3, 0) != 0);
                i_flush <= ($urandom_range(15, 0) == 0);
            end
        end

        @(posedge clk);
        i_issue <= random_issue(1'b0);
        i_flush <= 1'b0;
        repeat (IDLE_CYCLES) @(posedge clk);
        @(negedge clk);

        if (n_bcast == 0 || n_redirect == 0 || n_dropped == 0) begin
            $display("too little activity: %0d broadcasts, %0d redirects, %0d flush drops",
                     n_bcast, n_redirect, n_dropped);
            $display("RESULT: FAIL");
            $fatal(1, "stimulus did not exercise the unit");
        end else begin
            $display("%0d broadcasts checked, %0d redirects, %0d flush drops",
                     n_bcast, n_redirect, n_dropped);
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

/* verilog/ieu.sv */
// integer execution unit top; fixed two-cycle latency, no back-pressure, flush is a level
`timescale 1ns/1ps
`default_nettype none

module ieu
    import procyon_types::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_flush,
    input  ieu_issue_t i_issue,
    output ieu_cdb_t   o_cdb
);

    ieu_ex_in_t ex_in;
    ieu_cdb_t   ex_cdb;  // unregistered broadcast straight out of the ALU

    ieu_id ieu_id_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_issue (i_issue),
        .o_ex    (ex_in)
    );

    ieu_ex ieu_ex_i (
        .i_ex  (ex_in),
        .o_cdb (ex_cdb)
    );

    ieu_wb ieu_wb_i (
        .clk     (clk),
        .i_reset (i_reset),
        .i_flush (i_flush),
        .i_cdb   (ex_cdb),
        .o_cdb   (o_cdb)
    );

endmodule

`default_nettype wire

/* verilog/ieu_wb.sv */
// writeback register; owns its CDB slot outright, so there is no stall or arbitration
`timescale 1ns/1ps
`default_nettype none

module ieu_wb
    import procyon_types::*;
(
    input  logic     clk,
    input  logic     i_reset,
    input  logic     i_flush,
    input  ieu_cdb_t i_cdb,
    output ieu_cdb_t o_cdb
);

    always_ff @(posedge clk) begin
        o_cdb.data <= i_cdb.data;
        o_cdb.addr <= i_cdb.addr;
        o_cdb.tag  <= i_cdb.tag;

        if (i_reset || i_flush) begin
            o_cdb.valid    <= 1'b0;
            o_cdb.redirect <= 1'b0;
        end else begin
            o_cdb.valid    <= i_cdb.valid;
            o_cdb.redirect <= i_cdb.valid & i_cdb.redirect;  // execute raises it on empty slots
        end
    end

    // the reorder buffer acts on redirect without looking at valid
    assert property (@(posedge clk) disable iff (i_reset)
        o_cdb.redirect |-> o_cdb.valid)
        else $error("redirect without valid on tag %0d", o_cdb.tag);

endmodule

`default_nettype wire

/* verilog/ieu_ex.sv */
// execute stage, purely combinational; JALR target keeps bit 0 as computed
`timescale 1ns/1ps
`default_nettype none

`include "common.svh"

module ieu_ex
    import procyon_types::*;
(
    input  ieu_ex_in_t i_ex,
    output ieu_cdb_t   o_cdb
);

    procyon_data_t            result;
    logic [`DATA_WIDTH*2-1:0] e_src_a;  // sign-extended copy so SRA is a plain shift
    logic [`DATA_WIDTH*2-1:0] sra_wide;
    procyon_signed_data_t     s_src_a;
    procyon_signed_data_t     s_src_b;

    assign e_src_a  = {{(`DATA_WIDTH){i_ex.src_a[`DATA_WIDTH-1]}}, i_ex.src_a};
    assign sra_wide = e_src_a >> i_ex.shamt;
    assign s_src_a  = i_ex.src_a;
    assign s_src_b  = i_ex.src_b;

    always_comb begin
        case (i_ex.alu_func)
            ALU_FUNC_ADD: result = i_ex.src_a + i_ex.src_b;
            ALU_FUNC_SUB: result = i_ex.src_a - i_ex.src_b;
            ALU_FUNC_AND: result = i_ex.src_a & i_ex.src_b;
            ALU_FUNC_OR:  result = i_ex.src_a | i_ex.src_b;
            ALU_FUNC_XOR: result = i_ex.src_a ^ i_ex.src_b;
            ALU_FUNC_SLL: result = i_ex.src_a << i_ex.shamt;
            ALU_FUNC_SRL: result = i_ex.src_a >> i_ex.shamt;
            ALU_FUNC_SRA: result = sra_wide[`DATA_WIDTH-1:0];
            ALU_FUNC_EQ:  result = procyon_data_t'(i_ex.src_a == i_ex.src_b);
            ALU_FUNC_NE:  result = procyon_data_t'(i_ex.src_a != i_ex.src_b);
            ALU_FUNC_LT:  result = procyon_data_t'(s_src_a < s_src_b);
            ALU_FUNC_LTU: result = procyon_data_t'(i_ex.src_a < i_ex.src_b);
            ALU_FUNC_GE:  result = procyon_data_t'(s_src_a >= s_src_b);
            ALU_FUNC_GEU: result = procyon_data_t'(i_ex.src_a >= i_ex.src_b);
            default:      result = '0;
        endcase
    end

    // jumps link iaddr + 4 and carry the target in addr
    // branches carry the taken target and the compare bit decides the redirect
    always_comb begin
        o_cdb.valid = i_ex.valid;
        o_cdb.tag   = i_ex.tag;

        if (i_ex.jmp) begin
            o_cdb.data     = procyon_data_t'(i_ex.iaddr + procyon_addr_t'(4));
            o_cdb.addr     = procyon_addr_t'(result);
            o_cdb.redirect = 1'b1;
        end else if (i_ex.br) begin
            o_cdb.data     = result;
            o_cdb.addr     = i_ex.iaddr + procyon_addr_t'(i_ex.imm_b);
            o_cdb.redirect = result[0];
        end else begin
            o_cdb.data     = result;
            o_cdb.addr     = '0;
            o_cdb.redirect = 1'b0;
        end
    end

endmodule

`default_nettype wire

/* verilog/ieu_id.sv */
// decode stage; expects only supported opcodes from the dispatcher, anything else decodes as ADD
`timescale 1ns/1ps
`default_nettype none

module ieu_id
    import procyon_types::*;
(
    input  logic       clk,
    input  logic       i_reset,
    input  logic       i_flush,
    input  ieu_issue_t i_issue,
    output ieu_ex_in_t o_ex
);

    procyon_alu_func_t alu_func;
    procyon_data_t     src_a;
    procyon_data_t     src_b;
    logic              use_imm;
    logic              is_sub;
    logic              is_jmp;
    logic              is_br;
    ieu_ex_in_t        ex_d;

    assign is_jmp = (i_issue.opcode == OPCODE_JAL) || (i_issue.opcode == OPCODE_JALR);
    assign is_br  = (i_issue.opcode == OPCODE_BRANCH);

    // JAL needs its immediate as operand b too, the target is iaddr + imm
    assign use_imm = i_issue.opcode inside {OPCODE_OPIMM, OPCODE_JALR, OPCODE_LUI,
                                            OPCODE_AUIPC, OPCODE_JAL};

    // bit 30 only means SUB on register ops, on ADDI it is part of the immediate
    assign is_sub = (i_issue.opcode == OPCODE_OP) && i_issue.funct7_5;

    always_comb begin
        case (i_issue.opcode)
            OPCODE_LUI:                src_a = '0;
            OPCODE_AUIPC, OPCODE_JAL:  src_a = i_issue.iaddr;
            default:                   src_a = i_issue.src_a;
        endcase
    end

    assign src_b = use_imm ? i_issue.imm : i_issue.src_b;

    always_comb begin
        alu_func = ALU_FUNC_ADD;
        case (i_issue.opcode)
            OPCODE_OP, OPCODE_OPIMM: begin
                case (i_issue.funct3)
                    FUNCT3_ADD:  alu_func = is_sub ? ALU_FUNC_SUB : ALU_FUNC_ADD;
                    FUNCT3_SLL:  alu_func = ALU_FUNC_SLL;
                    FUNCT3_SLT:  alu_func = ALU_FUNC_LT;
                    FUNCT3_SLTU: alu_func = ALU_FUNC_LTU;
                    FUNCT3_XOR:  alu_func = ALU_FUNC_XOR;
                    FUNCT3_SR:   alu_func = i_issue.funct7_5 ? ALU_FUNC_SRA : ALU_FUNC_SRL;
                    FUNCT3_OR:   alu_func = ALU_FUNC_OR;
                    FUNCT3_AND:  alu_func = ALU_FUNC_AND;
                    default:     alu_func = ALU_FUNC_ADD;
                endcase
            end
            OPCODE_BRANCH: begin
                case (i_issue.funct3)
                    FUNCT3_BEQ:  alu_func = ALU_FUNC_EQ;
                    FUNCT3_BNE:  alu_func = ALU_FUNC_NE;
                    FUNCT3_BLT:  alu_func = ALU_FUNC_LT;
                    FUNCT3_BGE:  alu_func = ALU_FUNC_GE;
                    FUNCT3_BLTU: alu_func = ALU_FUNC_LTU;
                    FUNCT3_BGEU: alu_func = ALU_FUNC_GEU;
                    default:     alu_func = ALU_FUNC_ADD;
                endcase
            end
            default: alu_func = ALU_FUNC_ADD;  // LUI, AUIPC and both jumps just add
        endcase
    end

    always_comb begin
        ex_d.valid    = i_issue.valid;
        ex_d.alu_func = alu_func;
        ex_d.src_a    = src_a;
        ex_d.src_b    = src_b;
        ex_d.iaddr    = i_issue.iaddr;
        ex_d.imm_b    = i_issue.imm;
        ex_d.shamt    = src_b[SHAMT_WIDTH-1:0];
        ex_d.tag      = i_issue.tag;
        ex_d.jmp      = is_jmp;
        ex_d.br       = is_br;
    end

    always_ff @(posedge clk) begin
        o_ex <= ex_d;
        if (i_reset || i_flush) begin
            o_ex.valid <= 1'b0;  // a flush squashes whatever is being captured
        end
    end

    // the dispatcher only ever issues the classes this unit executes
    assert property (@(posedge clk) disable iff (i_reset)
        i_issue.valid |-> i_issue.opcode inside {OPCODE_OP, OPCODE_OPIMM, OPCODE_LUI,
                                                 OPCODE_AUIPC, OPCODE_JAL, OPCODE_JALR,
                                                 OPCODE_BRANCH})
        else $error("unsupported opcode issued: %b", i_issue.opcode);

    // execute relies on jmp and br being exclusive when it picks data and addr
    assert property (@(posedge clk) disable iff (i_reset)
        o_ex.valid |-> !(o_ex.jmp && o_ex.br))
        else $error("jmp and br both set for tag %0d", o_ex.tag);

endmodule

`default_nettype wire

/* verilog/procyon_types.sv */
// shared types for the integer execution unit; RV32I opcodes only, no loads, stores or M extension
`default_nettype none

`include "common.svh"

package procyon_types;

    localparam TAG_WIDTH   = 6;  // reorder buffer depth of 64
    localparam SHAMT_WIDTH = 5;

    // funct3 encodings for OP and OP-IMM
    localparam logic [2:0] FUNCT3_ADD  = 3'b000;
    localparam logic [2:0] FUNCT3_SLL  = 3'b001;
    localparam logic [2:0] FUNCT3_SLT  = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU = 3'b011;
    localparam logic [2:0] FUNCT3_XOR  = 3'b100;
    localparam logic [2:0] FUNCT3_SR   = 3'b101;
    localparam logic [2:0] FUNCT3_OR   = 3'b110;
    localparam logic [2:0] FUNCT3_AND  = 3'b111;

    // funct3 encodings for the conditional branches
    localparam logic [2:0] FUNCT3_BEQ  = 3'b000;
    localparam logic [2:0] FUNCT3_BNE  = 3'b001;
    localparam logic [2:0] FUNCT3_BLT  = 3'b100;
    localparam logic [2:0] FUNCT3_BGE  = 3'b101;
    localparam logic [2:0] FUNCT3_BLTU = 3'b110;
    localparam logic [2:0] FUNCT3_BGEU = 3'b111;

    typedef logic        [`DATA_WIDTH-1:0] procyon_data_t;
    typedef logic signed [`DATA_WIDTH-1:0] procyon_signed_data_t;
    typedef logic        [`ADDR_WIDTH-1:0] procyon_addr_t;
    typedef logic        [TAG_WIDTH-1:0]   procyon_tag_t;
    typedef logic        [SHAMT_WIDTH-1:0] procyon_shamt_t;

    typedef enum logic [3:0] {
        ALU_FUNC_ADD = 4'b0000,
        ALU_FUNC_SUB = 4'b0001,
        ALU_FUNC_AND = 4'b0010,
        ALU_FUNC_OR  = 4'b0011,
        ALU_FUNC_XOR = 4'b0100,
        ALU_FUNC_SLL = 4'b0101,
        ALU_FUNC_SRL = 4'b0110,
        ALU_FUNC_SRA = 4'b0111,
        ALU_FUNC_EQ  = 4'b1000,
        ALU_FUNC_NE  = 4'b1001,
        ALU_FUNC_LT  = 4'b1010,
        ALU_FUNC_LTU = 4'b1011,
        ALU_FUNC_GE  = 4'b1100,
        ALU_FUNC_GEU = 4'b1101
    } procyon_alu_func_t;

    typedef enum logic [6:0] {
        OPCODE_OPIMM  = 7'b0010011,
        OPCODE_LUI    = 7'b0110111,
        OPCODE_AUIPC  = 7'b0010111,
        OPCODE_OP     = 7'b0110011,
        OPCODE_JAL    = 7'b1101111,
        OPCODE_JALR   = 7'b1100111,
        OPCODE_BRANCH = 7'b1100011
    } procyon_opcode_t;

    // imm arrives already sign-extended for the instruction's format
    typedef struct packed {
        logic            valid;
        procyon_opcode_t opcode;
        logic [2:0]      funct3;
        logic            funct7_5;
        procyon_addr_t   iaddr;
        procyon_data_t   src_a;
        procyon_data_t   src_b;
        procyon_data_t   imm;
        procyon_tag_t    tag;
    } ieu_issue_t;

    typedef struct packed {
        logic              valid;
        procyon_alu_func_t alu_func;
        procyon_data_t     src_a;
        procyon_data_t     src_b;
        procyon_addr_t     iaddr;
        procyon_data_t     imm_b;
        procyon_shamt_t    shamt;
        procyon_tag_t      tag;
        logic              jmp;
        logic              br;
    } ieu_ex_in_t;

    typedef struct packed {
        logic          valid;
        procyon_data_t data;
        procyon_addr_t addr;
        procyon_tag_t  tag;
        logic          redirect;
    } ieu_cdb_t;

endpackage

`default_nettype wire

/* include/common.svh */
// core-wide widths, fixed at 32 bits; the rest of the core assumes data and address match
`ifndef COMMON_SVH_
`define COMMON_SVH_

// register and ALU datapath width
`define DATA_WIDTH 32

// instruction address width, kept equal to DATA_WIDTH so targets fit in a data word
`define ADDR_WIDTH 32

`endif
